// ==== common/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// width of every data word and program counter held in the buffer
`define ROB_XLEN 32

// number of buffer entries, which has to be a power of two so that the
// entry index wraps on its own
`define ROB_BUF_SIZE 8

// entry index plus one phase bit
// the phase bit tells a full buffer apart from an empty one
`define ROB_TAG_WIDTH 4

// tails of the load and store queues saved with each entry
`define ROB_LDQ_TAG_WIDTH 3
`define ROB_STQ_TAG_WIDTH 3

`endif

// ==== common/rob_pkg.sv ====
`include "rob_cfg.svh"

package rob_pkg;

	// class of an in-flight instruction, given by dispatch at allocation
	// a branch keeps the CDB data as its next instruction and not as a value
	// a store may only commit once the address bus has named its tag
	typedef enum logic [1:0] {
		class_alu    = 2'b00,
		class_branch = 2'b01,
		class_load   = 2'b10,
		class_store  = 2'b11
	} instr_class_e;

	// width of the bare entry index
	// tags carry one more bit on top, the phase bit, which is stripped
	// off wherever a tag selects an entry
	localparam int rob_index_width = $clog2(`ROB_BUF_SIZE);

endpackage

// ==== design/lsb_priority_encoder.sv ====
module lsb_priority_encoder #(
	parameter int n = 8,
	// a single input bit still gets a one-bit index
	localparam int index_width = (n > 1) ? $clog2(n) : 1
) (
	input  logic [n-1:0]           bits,
	output logic [index_width-1:0] index,
	output logic                   found
);

	assign found = |bits;

	// scan from the top down so that the lowest set bit is written last
	// with no bit set the index stays at zero
	always_comb begin
		index = '0;
		for (int i = n - 1; i >= 0; i--) begin
			if (bits[i]) begin
				index = index_width'(i);
			end
		end
	end

endmodule

// ==== rob/reorder_buffer.sv ====
`include "rob_cfg.svh"

module reorder_buffer import rob_pkg::*; (
	input  logic                                             clk,
	input  logic                                             reset,

	// allocation from dispatch, one entry per cycle at tail
	input  logic                                             alloc_en,
	input  instr_class_e                                     alloc_class,
	// register index of rd, five bits for the RISC-V register file
	input  logic [4:0]                                       alloc_destination,
	input  logic [`ROB_XLEN-1:0]                             alloc_value,
	input  logic                                             alloc_data_ready,
	input  logic [`ROB_XLEN-1:0]                             alloc_pc,
	input  logic [`ROB_LDQ_TAG_WIDTH-1:0]                    alloc_ldq_tail,
	input  logic [`ROB_STQ_TAG_WIDTH-1:0]                    alloc_stq_tail,

	// common data bus write-back
	input  logic                                             cdb_valid,
	input  logic [`ROB_XLEN-1:0]                             cdb_data,
	input  logic [`ROB_TAG_WIDTH-1:0]                        cdb_tag,
	input  logic                                             cdb_exception,
	input  logic                                             cdb_branch_mispredict,

	// store address bus from the address generation unit
	input  logic                                             agu_valid,
	input  logic [`ROB_TAG_WIDTH-1:0]                        agu_tag,

	// recovery request from the flusher
	input  logic                                             flush,
	input  logic [`ROB_TAG_WIDTH-1:0]                        flush_start_tag,

	// per-entry state the flusher searches
	output logic [`ROB_BUF_SIZE-1:0]                         entry_branch_mispredict,
	output logic [`ROB_BUF_SIZE-1:0]                         entry_exception,
	output logic [`ROB_BUF_SIZE-1:0][`ROB_XLEN-1:0]          entry_next_instruction,
	output logic [`ROB_BUF_SIZE-1:0][`ROB_LDQ_TAG_WIDTH-1:0] entry_ldq_tail,
	output logic [`ROB_BUF_SIZE-1:0][`ROB_STQ_TAG_WIDTH-1:0] entry_stq_tail,

	// the head entry, valid as a commit while commit is high
	output logic                                             commit,
	output instr_class_e                                     commit_class,
	output logic [4:0]                                       commit_destination,
	output logic [`ROB_XLEN-1:0]                             commit_value,
	output logic                                             commit_mispredict,
	output logic                                             commit_exception,

	output logic [`ROB_TAG_WIDTH-1:0]                        head,
	output logic [`ROB_TAG_WIDTH-1:0]                        tail,
	output logic                                             empty,
	output logic                                             full
);

	// control state of each entry
	logic [`ROB_BUF_SIZE-1:0] entry_valid;
	logic [`ROB_BUF_SIZE-1:0] entry_data_ready;
	// only ever set on stores
	logic [`ROB_BUF_SIZE-1:0] entry_address_valid;

	// payload of each entry
	instr_class_e               entry_class [`ROB_BUF_SIZE];
	logic [4:0]                 entry_destination [`ROB_BUF_SIZE];
	logic [`ROB_XLEN-1:0]       entry_value [`ROB_BUF_SIZE];

	// registered tail, the visible tail follows the start tag during a flush
	logic [`ROB_TAG_WIDTH-1:0]  tail_q;
	logic [`ROB_TAG_WIDTH-1:0]  n_elements;

	// tags with the phase bit removed, so that they can select an entry
	logic [rob_index_width-1:0] head_index;
	logic [rob_index_width-1:0] tail_index;
	logic [rob_index_width-1:0] cdb_index;
	logic [rob_index_width-1:0] agu_index;

	// age of the flush start relative to head, from 0 up to the buffer size
	logic [`ROB_TAG_WIDTH-1:0]  flush_start_age;

	logic                       alloc_accept;

	// one bit per entry for each event that touches that entry this cycle
	logic [`ROB_BUF_SIZE-1:0]   alloc_hit;
	logic [`ROB_BUF_SIZE-1:0]   cdb_hit;
	logic [`ROB_BUF_SIZE-1:0]   agu_hit;
	logic [`ROB_BUF_SIZE-1:0]   commit_hit;
	logic [`ROB_BUF_SIZE-1:0]   flush_hit;

	// while a flush is pending the tail already points at the start tag
	// so empty and full see the buffer as it will be after the flush
	assign tail = flush ? flush_start_tag : tail_q;

	assign head_index = head[rob_index_width-1:0];
	assign tail_index = tail[rob_index_width-1:0];
	assign cdb_index  = cdb_tag[rob_index_width-1:0];
	assign agu_index  = agu_tag[rob_index_width-1:0];

	// the phase bit makes the difference reach the buffer size when full
	assign n_elements = tail - head;
	assign empty      = (n_elements == '0);
	assign full       = (n_elements == `ROB_TAG_WIDTH'(`ROB_BUF_SIZE));

	// dispatch is dropped while full or while recovering
	assign alloc_accept = alloc_en && !full && !flush;

	assign flush_start_age = flush_start_tag - head;

	always_comb begin
		logic [rob_index_width-1:0] age;
		for (int i = 0; i < `ROB_BUF_SIZE; i++) begin
			// distance of this entry from head, zero is the oldest
			age = rob_index_width'(i) - head_index;
			alloc_hit[i] = alloc_accept && (tail_index == rob_index_width'(i));
			cdb_hit[i] = cdb_valid && entry_valid[i] && (cdb_index == rob_index_width'(i));
			// the address bus is ignored for every class but stores
			agu_hit[i] = agu_valid && entry_valid[i] && (entry_class[i] == class_store)
				&& (agu_index == rob_index_width'(i));
			commit_hit[i] = commit && (head_index == rob_index_width'(i));
			// everything at or younger than the start tag goes away
			flush_hit[i] = flush && (`ROB_TAG_WIDTH'(age) >= flush_start_age);
		end
	end

	// head commits once its result is in, and for a store its address too
	assign commit = !empty && entry_data_ready[head_index]
		&& (entry_class[head_index] != class_store || entry_address_valid[head_index]);

	assign commit_class       = entry_class[head_index];
	assign commit_destination = entry_destination[head_index];
	assign commit_value       = entry_value[head_index];
	assign commit_mispredict  = entry_branch_mispredict[head_index];
	assign commit_exception   = entry_exception[head_index];

	// pointers and per-entry status bits
	always_ff @(posedge clk) begin
		if (!reset) begin
			head                    <= '0;
			tail_q                  <= '0;
			entry_valid             <= '0;
			entry_data_ready        <= '0;
			entry_address_valid     <= '0;
			entry_branch_mispredict <= '0;
			entry_exception         <= '0;
		end else begin
			// a flush rolls the tail back, else an accepted dispatch advances it
			if (flush) begin
				tail_q <= flush_start_tag;
			end else if (alloc_accept) begin
				tail_q <= tail_q + 1'b1;
			end
			if (commit) begin
				head <= head + 1'b1;
			end
			for (int i = 0; i < `ROB_BUF_SIZE; i++) begin
				if (flush_hit[i] || commit_hit[i]) begin
					entry_valid[i]             <= 1'b0;
					entry_data_ready[i]        <= 1'b0;
					entry_address_valid[i]     <= 1'b0;
					entry_branch_mispredict[i] <= 1'b0;
					entry_exception[i]         <= 1'b0;
				end else begin
					if (alloc_hit[i]) begin
						entry_valid[i]             <= 1'b1;
						entry_data_ready[i]        <= alloc_data_ready;
						entry_address_valid[i]     <= 1'b0;
						entry_branch_mispredict[i] <= 1'b0;
						entry_exception[i]         <= 1'b0;
					end
					if (cdb_hit[i]) begin
						// an excepting entry is never marked ready, the flush
						// removes it and the front end retries it
						if (cdb_exception) begin
							entry_exception[i] <= 1'b1;
						end else begin
							entry_data_ready[i] <= 1'b1;
							if (entry_class[i] == class_branch) begin
								entry_branch_mispredict[i] <= cdb_branch_mispredict;
							end
						end
					end
					if (agu_hit[i]) begin
						entry_address_valid[i] <= 1'b1;
					end
				end
			end
		end
	end

	// entry contents, read only while the matching valid bit is set
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ROB_BUF_SIZE; i++) begin
			if (alloc_hit[i]) begin
				entry_class[i]            <= alloc_class;
				entry_destination[i]      <= alloc_destination;
				entry_value[i]            <= alloc_value;
				// the pc is where an exception restarts fetch
				entry_next_instruction[i] <= alloc_pc;
				entry_ldq_tail[i]         <= alloc_ldq_tail;
				entry_stq_tail[i]         <= alloc_stq_tail;
			end else if (cdb_hit[i] && !cdb_exception) begin
				// a branch result is its resolved target, not a register value
				if (entry_class[i] == class_branch) begin
					entry_next_instruction[i] <= cdb_data;
				end else begin
					entry_value[i] <= cdb_data;
				end
			end
		end
	end

endmodule

// ==== rob/buffer_flusher.sv ====
`include "rob_cfg.svh"

module buffer_flusher import rob_pkg::*; (
	input  logic [`ROB_BUF_SIZE-1:0]                         entry_branch_mispredict,
	input  logic [`ROB_BUF_SIZE-1:0]                         entry_exception,
	input  logic [`ROB_BUF_SIZE-1:0][`ROB_XLEN-1:0]          entry_next_instruction,
	input  logic [`ROB_BUF_SIZE-1:0][`ROB_LDQ_TAG_WIDTH-1:0] entry_ldq_tail,
	input  logic [`ROB_BUF_SIZE-1:0][`ROB_STQ_TAG_WIDTH-1:0] entry_stq_tail,
	input  logic [`ROB_TAG_WIDTH-1:0]                        head,

	output logic                                             flush,
	// becomes the new tail of the buffer
	output logic [`ROB_TAG_WIDTH-1:0]                        flush_start_tag,
	output logic [`ROB_XLEN-1:0]                             redirect_pc,
	output logic [`ROB_LDQ_TAG_WIDTH-1:0]                    ldq_new_tail,
	output logic [`ROB_STQ_TAG_WIDTH-1:0]                    stq_new_tail
);

	logic [rob_index_width-1:0] head_index;

	// cause bits rotated so that bit zero is the entry at head
	logic [`ROB_BUF_SIZE-1:0]   rotated_mispredict;
	logic [`ROB_BUF_SIZE-1:0]   rotated_exception;
	logic [`ROB_BUF_SIZE-1:0]   rotated_cause;

	// oldest cause, as a distance from head and as a real entry index
	logic [rob_index_width-1:0] rotated_oldest;
	logic [rob_index_width-1:0] oldest_index;
	logic                       cause_is_exception;
	logic [`ROB_TAG_WIDTH-1:0]  cause_tag;

	assign head_index = head[rob_index_width-1:0];

	always_comb begin
		logic [rob_index_width-1:0] src;
		for (int i = 0; i < `ROB_BUF_SIZE; i++) begin
			// the index add wraps around the end of the buffer
			src = rob_index_width'(i) + head_index;
			rotated_mispredict[i] = entry_branch_mispredict[src];
			rotated_exception[i]  = entry_exception[src];
		end
	end

	assign rotated_cause = rotated_mispredict | rotated_exception;

	// the lowest rotated bit is the cause closest to head, the oldest one
	lsb_priority_encoder #(
		.n(`ROB_BUF_SIZE)
	) oldest_cause_finder (
		.bits (rotated_cause),
		.index(rotated_oldest),
		.found(flush)
	);

	assign oldest_index       = rotated_oldest + head_index;
	assign cause_is_exception = rotated_exception[rotated_oldest];

	// adding to the full head tag keeps the phase bit right across a wrap
	assign cause_tag = head + `ROB_TAG_WIDTH'(rotated_oldest);

	// an excepting entry is flushed itself, a mispredicted branch stays
	// in the buffer and commits, so only what follows it is removed
	assign flush_start_tag = cause_is_exception ? cause_tag : cause_tag + 1'b1;

	// pc of the excepting entry or the resolved target of the branch
	assign redirect_pc  = entry_next_instruction[oldest_index];
	assign ldq_new_tail = entry_ldq_tail[oldest_index];
	assign stq_new_tail = entry_stq_tail[oldest_index];

endmodule

// ==== design/rob_core.sv ====
`include "rob_cfg.svh"

module rob_core import rob_pkg::*; (
	input  logic                          clk,
	input  logic                          reset,

	// dispatch
	input  logic                          alloc_en,
	input  instr_class_e                  alloc_class,
	input  logic [4:0]                    alloc_destination,
	input  logic [`ROB_XLEN-1:0]          alloc_value,
	input  logic                          alloc_data_ready,
	input  logic [`ROB_XLEN-1:0]          alloc_pc,
	input  logic [`ROB_LDQ_TAG_WIDTH-1:0] alloc_ldq_tail,
	input  logic [`ROB_STQ_TAG_WIDTH-1:0] alloc_stq_tail,

	// common data bus
	input  logic                          cdb_valid,
	input  logic [`ROB_XLEN-1:0]          cdb_data,
	input  logic [`ROB_TAG_WIDTH-1:0]     cdb_tag,
	input  logic                          cdb_exception,
	input  logic                          cdb_branch_mispredict,

	// store address bus
	input  logic                          agu_valid,
	input  logic [`ROB_TAG_WIDTH-1:0]     agu_tag,

	// commit of the head entry
	output logic                          commit,
	output instr_class_e                  commit_class,
	output logic [4:0]                    commit_destination,
	output logic [`ROB_XLEN-1:0]          commit_value,
	output logic                          commit_mispredict,
	output logic                          commit_exception,

	output logic [`ROB_TAG_WIDTH-1:0]     head,
	output logic [`ROB_TAG_WIDTH-1:0]     tail,
	output logic                          empty,
	output logic                          full,

	// recovery towards the front end and the memory queues
	output logic                          flush,
	output logic [`ROB_XLEN-1:0]          redirect_pc,
	output logic [`ROB_LDQ_TAG_WIDTH-1:0] ldq_new_tail,
	output logic [`ROB_STQ_TAG_WIDTH-1:0] stq_new_tail
);

	// entry state from the buffer into the flusher
	logic [`ROB_BUF_SIZE-1:0]                         entry_branch_mispredict;
	logic [`ROB_BUF_SIZE-1:0]                         entry_exception;
	logic [`ROB_BUF_SIZE-1:0][`ROB_XLEN-1:0]          entry_next_instruction;
	logic [`ROB_BUF_SIZE-1:0][`ROB_LDQ_TAG_WIDTH-1:0] entry_ldq_tail;
	logic [`ROB_BUF_SIZE-1:0][`ROB_STQ_TAG_WIDTH-1:0] entry_stq_tail;

	// where the buffer rolls its tail back to
	logic [`ROB_TAG_WIDTH-1:0]                        flush_start_tag;

	reorder_buffer reorder_buffer_i (
		.clk                    (clk),
		.reset                  (reset),
		.alloc_en               (alloc_en),
		.alloc_class            (alloc_class),
		.alloc_destination      (alloc_destination),
		.alloc_value            (alloc_value),
		.alloc_data_ready       (alloc_data_ready),
		.alloc_pc               (alloc_pc),
		.alloc_ldq_tail         (alloc_ldq_tail),
		.alloc_stq_tail         (alloc_stq_tail),
		.cdb_valid              (cdb_valid),
		.cdb_data               (cdb_data),
		.cdb_tag                (cdb_tag),
		.cdb_exception          (cdb_exception),
		.cdb_branch_mispredict  (cdb_branch_mispredict),
		.agu_valid              (agu_valid),
		.agu_tag                (agu_tag),
		.flush                  (flush),
		.flush_start_tag        (flush_start_tag),
		.entry_branch_mispredict(entry_branch_mispredict),
		.entry_exception        (entry_exception),
		.entry_next_instruction (entry_next_instruction),
		.entry_ldq_tail         (entry_ldq_tail),
		.entry_stq_tail         (entry_stq_tail),
		.commit                 (commit),
		.commit_class           (commit_class),
		.commit_destination     (commit_destination),
		.commit_value           (commit_value),
		.commit_mispredict      (commit_mispredict),
		.commit_exception       (commit_exception),
		.head                   (head),
		.tail                   (tail),
		.empty                  (empty),
		.full                   (full)
	);

	buffer_flusher buffer_flusher_i (
		.entry_branch_mispredict(entry_branch_mispredict),
		.entry_exception        (entry_exception),
		.entry_next_instruction (entry_next_instruction),
		.entry_ldq_tail         (entry_ldq_tail),
		.entry_stq_tail         (entry_stq_tail),
		.head                   (head),
		.flush                  (flush),
		.flush_start_tag        (flush_start_tag),
		.redirect_pc            (redirect_pc),
		.ldq_new_tail           (ldq_new_tail),
		.stq_new_tail           (stq_new_tail)
	);

endmodule

// ==== tb/rob_core_tb.sv ====
`include "rob_cfg.svh"

module rob_core_tb import rob_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// cycle cost of each directed test with reset in front
	localparam int reset_cycles        = 5;
	localparam int in_order_cycles     = 12;
	localparam int out_of_order_cycles = 16;
	localparam int store_cycles        = 16;
	localparam int mispredict_cycles   = 20;
	localparam int exception_cycles    = 16;
	localparam int wraparound_cycles   = 60;
	localparam int cycle_limit = reset_cycles + in_order_cycles + out_of_order_cycles
		+ store_cycles + mispredict_cycles + exception_cycles + wraparound_cycles + 50;
	// how long a ready head may take to show up as a commit
	localparam int commit_wait_limit   = 8;
	localparam int tag_count           = 1 << `ROB_TAG_WIDTH;

	logic                          clk;
	logic                          reset;
	logic                          alloc_en;
	instr_class_e                  alloc_class;
	logic [4:0]                    alloc_destination;
	logic [`ROB_XLEN-1:0]          alloc_value;
	logic                          alloc_data_ready;
	logic [`ROB_XLEN-1:0]          alloc_pc;
	logic [`ROB_LDQ_TAG_WIDTH-1:0] alloc_ldq_tail;
	logic [`ROB_STQ_TAG_WIDTH-1:0] alloc_stq_tail;
	logic                          cdb_valid;
	logic [`ROB_XLEN-1:0]          cdb_data;
	logic [`ROB_TAG_WIDTH-1:0]     cdb_tag;
	logic                          cdb_exception;
	logic                          cdb_branch_mispredict;
	logic                          agu_valid;
	logic [`ROB_TAG_WIDTH-1:0]     agu_tag;
	logic                          commit;
	instr_class_e                  commit_class;
	logic [4:0]                    commit_destination;
	logic [`ROB_XLEN-1:0]          commit_value;
	logic                          commit_mispredict;
	logic                          commit_exception;
	logic [`ROB_TAG_WIDTH-1:0]     head;
	logic [`ROB_TAG_WIDTH-1:0]     tail;
	logic                          empty;
	logic                          full;
	logic                          flush;
	logic [`ROB_XLEN-1:0]          redirect_pc;
	logic [`ROB_LDQ_TAG_WIDTH-1:0] ldq_new_tail;
	logic [`ROB_STQ_TAG_WIDTH-1:0] stq_new_tail;

	// reference model of every entry indexed by the full tag
	instr_class_e                  model_class [tag_count];
	logic [4:0]                    model_dest [tag_count];
	logic [`ROB_XLEN-1:0]          model_value [tag_count];
	logic [`ROB_XLEN-1:0]          model_pc [tag_count];
	logic [`ROB_LDQ_TAG_WIDTH-1:0] model_ldq [tag_count];
	logic [`ROB_STQ_TAG_WIDTH-1:0] model_stq [tag_count];
	logic                          model_mispredict [tag_count];
	// where the next allocation lands
	logic [`ROB_TAG_WIDTH-1:0]     exp_tail;

	logic [31:0] lfsr_state = 32'h7fa18dd5;
	int          cycle_count = 0;
	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;

	rob_core rob_core_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// hard stop in case a test hangs somewhere
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("the run was stopped after %0d cycles before the tests ended", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// fibonacci lfsr with taps 32, 22, 2 and 1 that steps once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic        feedback;
		r = '0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			r = {r[30:0], lfsr_state[31]};
			lfsr_state = {lfsr_state[30:0], feedback};
		end
		return r;
	endfunction

	task automatic check_class(input instr_class_e got, input instr_class_e exp,
		input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_word(input logic [`ROB_XLEN-1:0] got, input logic [`ROB_XLEN-1:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_tag(input logic [`ROB_TAG_WIDTH-1:0] got,
		input logic [`ROB_TAG_WIDTH-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_queue_tail(input logic [`ROB_LDQ_TAG_WIDTH-1:0] got,
		input logic [`ROB_LDQ_TAG_WIDTH-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_register(input logic [4:0] got, input logic [4:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	// one dispatch with a random payload into the entry at the current tail
	task automatic allocate(input instr_class_e cls, input logic ready,
		output logic [`ROB_TAG_WIDTH-1:0] tag);
		tag = exp_tail;
		model_class[tag]      = cls;
		model_dest[tag]       = 5'(random_bits(5));
		model_value[tag]      = random_bits(32);
		model_pc[tag]         = random_bits(32);
		model_ldq[tag]        = `ROB_LDQ_TAG_WIDTH'(random_bits(`ROB_LDQ_TAG_WIDTH));
		model_stq[tag]        = `ROB_STQ_TAG_WIDTH'(random_bits(`ROB_STQ_TAG_WIDTH));
		model_mispredict[tag] = 1'b0;
		alloc_en          = 1'b1;
		alloc_class       = cls;
		alloc_destination = model_dest[tag];
		alloc_value       = model_value[tag];
		alloc_data_ready  = ready;
		alloc_pc          = model_pc[tag];
		alloc_ldq_tail    = model_ldq[tag];
		alloc_stq_tail    = model_stq[tag];
		@(negedge clk);
		alloc_en = 1'b0;
		exp_tail = exp_tail + 1'b1;
	endtask

	// a branch keeps the data as its target while other classes take it as value
	task automatic write_back(input logic [`ROB_TAG_WIDTH-1:0] tag,
		input logic [`ROB_XLEN-1:0] data, input logic exception, input logic mispredict);
		cdb_valid             = 1'b1;
		cdb_tag               = tag;
		cdb_data              = data;
		cdb_exception         = exception;
		cdb_branch_mispredict = mispredict;
		if (!exception) begin
			if (model_class[tag] == class_branch) begin
				model_mispredict[tag] = mispredict;
			end else begin
				model_value[tag] = data;
			end
		end
		@(negedge clk);
		cdb_valid             = 1'b0;
		cdb_exception         = 1'b0;
		cdb_branch_mispredict = 1'b0;
	endtask

	task automatic send_address(input logic [`ROB_TAG_WIDTH-1:0] tag);
		agu_valid = 1'b1;
		agu_tag   = tag;
		@(negedge clk);
		agu_valid = 1'b0;
	endtask

	// waits for the head to commit, checks it against the model, then lets it retire
	task automatic expect_commit(input logic [`ROB_TAG_WIDTH-1:0] tag);
		int waited;
		waited = 0;
		while (!commit && waited < commit_wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!commit) begin
			failures++;
			$display("at %0t the entry with tag %0d did not commit in time", $time, tag);
		end else begin
			check_tag(head, tag, "head at commit");
			check_class(commit_class, model_class[tag], "commit_class");
			check_register(commit_destination, model_dest[tag], "commit_destination");
			check_word(commit_value, model_value[tag], "commit_value");
			check_bit(commit_mispredict, model_mispredict[tag], "commit_mispredict");
			check_bit(commit_exception, 1'b0, "commit_exception");
			@(negedge clk);
		end
	endtask

	task automatic in_order_commit();
		logic [`ROB_TAG_WIDTH-1:0] tag;
		check_bit(empty, 1'b1, "empty after reset");
		check_bit(commit, 1'b0, "commit after reset");
		check_bit(flush, 1'b0, "flush after reset");
		check_bit(full, 1'b0, "full after reset");
		check_tag(head, '0, "head after reset");
		check_tag(tail, exp_tail, "tail after reset");
		for (int k = 0; k < 4; k++) begin
			allocate(class_alu, 1'b1, tag);
			expect_commit(tag);
		end
		check_bit(empty, 1'b1, "empty after last ready entry");
		check_bit(commit, 1'b0, "commit on empty buffer");
	endtask

	task automatic out_of_order_completion();
		logic [`ROB_TAG_WIDTH-1:0] tags [3];
		for (int k = 0; k < 3; k++) begin
			allocate(class_load, 1'b0, tags[k]);
		end
		// the youngest finishes first and nothing may retire until the head does
		for (int k = 2; k >= 0; k--) begin
			check_bit(commit, 1'b0, "commit before head written back");
			write_back(tags[k], random_bits(32), 1'b0, 1'b0);
		end
		for (int k = 0; k < 3; k++) begin
			expect_commit(tags[k]);
		end
	endtask

	task automatic store_address_gating();
		logic [`ROB_TAG_WIDTH-1:0] store_tag;
		logic [`ROB_TAG_WIDTH-1:0] load_tag;
		allocate(class_store, 1'b1, store_tag);
		allocate(class_load, 1'b0, load_tag);
		check_bit(commit, 1'b0, "store commit before its address");
		// an address for the load marks nothing
		send_address(load_tag);
		check_bit(commit, 1'b0, "store commit after address for other entry");
		send_address(store_tag);
		expect_commit(store_tag);
		check_bit(commit, 1'b0, "load commit before its data");
		write_back(load_tag, random_bits(32), 1'b0, 1'b0);
		expect_commit(load_tag);
	endtask

	task automatic branch_mispredict_recovery();
		logic [`ROB_TAG_WIDTH-1:0] older_tag;
		logic [`ROB_TAG_WIDTH-1:0] branch_tag;
		logic [`ROB_TAG_WIDTH-1:0] young_tag;
		logic [`ROB_XLEN-1:0]      target;
		allocate(class_alu, 1'b0, older_tag);
		allocate(class_branch, 1'b0, branch_tag);
		allocate(class_alu, 1'b1, young_tag);
		allocate(class_alu, 1'b1, young_tag);
		target = random_bits(32);
		write_back(branch_tag, target, 1'b0, 1'b1);
		check_bit(flush, 1'b1, "flush after mispredict");
		check_word(redirect_pc, target, "redirect_pc after mispredict");
		check_queue_tail(ldq_new_tail, model_ldq[branch_tag], "ldq_new_tail");
		check_queue_tail(stq_new_tail, model_stq[branch_tag], "stq_new_tail");
		check_tag(tail, branch_tag + 1'b1, "tail after mispredict");
		// the branch survives while everything younger is gone
		exp_tail = branch_tag + 1'b1;
		write_back(older_tag, random_bits(32), 1'b0, 1'b0);
		expect_commit(older_tag);
		check_bit(flush, 1'b1, "flush held until branch commits");
		expect_commit(branch_tag);
		check_bit(flush, 1'b0, "flush after branch commit");
		check_bit(empty, 1'b1, "empty after branch commit");
		check_bit(commit, 1'b0, "commit of flushed entry");
		check_tag(tail, exp_tail, "tail after mispredict recovery");
	endtask

	task automatic exception_recovery();
		logic [`ROB_TAG_WIDTH-1:0] first_tag;
		logic [`ROB_TAG_WIDTH-1:0] fault_tag;
		logic [`ROB_TAG_WIDTH-1:0] last_tag;
		allocate(class_alu, 1'b0, first_tag);
		allocate(class_alu, 1'b0, fault_tag);
		allocate(class_alu, 1'b1, last_tag);
		write_back(fault_tag, random_bits(32), 1'b1, 1'b0);
		check_bit(flush, 1'b1, "flush after exception");
		check_word(redirect_pc, model_pc[fault_tag], "redirect_pc after exception");
		check_tag(tail, fault_tag, "tail after exception");
		exp_tail = fault_tag;
		@(negedge clk);
		// the excepting entry itself is removed, so the cause is gone
		check_bit(flush, 1'b0, "flush one cycle after exception");
		check_bit(commit, 1'b0, "commit with unready head");
		write_back(first_tag, random_bits(32), 1'b0, 1'b0);
		expect_commit(first_tag);
		check_bit(empty, 1'b1, "empty after exception recovery");
		check_bit(commit, 1'b0, "commit of flushed entry");
	endtask

	task automatic full_and_wraparound();
		logic [`ROB_TAG_WIDTH-1:0] tags [`ROB_BUF_SIZE];
		// two rounds so that both index wrap and phase flip get crossed
		for (int round = 0; round < 2; round++) begin
			for (int k = 0; k < `ROB_BUF_SIZE; k++) begin
				check_bit(full, 1'b0, "full before last entry");
				allocate(class_alu, 1'b0, tags[k]);
			end
			check_bit(full, 1'b1, "full with every entry in use");
			for (int k = 0; k < `ROB_BUF_SIZE; k++) begin
				write_back(tags[k], random_bits(32), 1'b0, 1'b0);
				expect_commit(tags[k]);
			end
			check_bit(empty, 1'b1, "empty after drain");
			check_tag(tail, exp_tail, "tail after drain");
		end
	endtask

	initial begin
		reset                 = 1'b0;
		alloc_en              = 1'b0;
		alloc_class           = class_alu;
		alloc_destination     = '0;
		alloc_value           = '0;
		alloc_data_ready      = 1'b0;
		alloc_pc              = '0;
		alloc_ldq_tail        = '0;
		alloc_stq_tail        = '0;
		cdb_valid             = 1'b0;
		cdb_data              = '0;
		cdb_tag               = '0;
		cdb_exception         = 1'b0;
		cdb_branch_mispredict = 1'b0;
		agu_valid             = 1'b0;
		agu_tag               = '0;
		exp_tail              = '0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b1;
		in_order_commit();
		out_of_order_completion();
		store_address_gating();
		branch_mispredict_recovery();
		exception_recovery();
		full_and_wraparound();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+common
common/rob_pkg.sv
design/lsb_priority_encoder.sv
rob/reorder_buffer.sv
rob/buffer_flusher.sv
design/rob_core.sv
tb/rob_core_tb.sv

// ==== Bender.yml ====
package:
  name: rob_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rob_pkg.sv
      - design/lsb_priority_encoder.sv
      - rob/reorder_buffer.sv
      - rob/buffer_flusher.sv
      - design/rob_core.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - tb/rob_core_tb.sv
